/* dv/uart_periph_props.sv */
`timescale 1ns/100ps

module uart_periph_props (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          ready,
    input logic [uart_pkg::CREDIT_W-1:0] credit,
    input logic                          tx_push
);

    // ------------------------------------------------------------
    // Bus handshake
    // ------------------------------------------------------------
    ready_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ready |=> !ready)
        else $error("ready held high for two cycles");

    // ------------------------------------------------------------
    // Transmit credits
    // ------------------------------------------------------------
    credit_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        credit <= uart_pkg::CREDIT_W'(uart_pkg::TX_FIFO_DEPTH))
        else $error("credit count above transmit FIFO depth");

    // No push may spend a credit that is not there
    push_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        tx_push |-> (credit != '0))
        else $error("tx_push with zero credits");

endmodule

bind uart_regs uart_periph_props i_uart_periph_props (
    .clk, .rst_n, .ready(mem_ret.ready), .credit, .tx_push
);

/* dv/uart_periph_tb.sv */
`timescale 1ns/100ps

module uart_periph_tb;

    localparam logic [7:0] BASE = 8'h02;    // Device window, addr[31:24]
    localparam int BUS_TIMEOUT  = 2000;     // Cycles per bus access
    localparam int LINE_TIMEOUT = 5000;     // Cycles to wait for a start bit

    logic                  clk;
    logic                  rst_n;
    mem_bus_pkg::mem_fwd_t mem_fwd;
    mem_bus_pkg::mem_ret_t mem_ret;
    logic                  rxd;
    logic                  txd;
    logic                  irq_rx_valid;

    int          errors;            // Failed checks, whole run
    int          errors_at_start;   // Snapshot per test
    int          tests_run;
    int          tests_failed;
    string       cur_test;
    logic [15:0] bit_cycles;        // Prescale known to the line models

    uart_periph #(.base_addr(BASE)) i_uart_periph (
        .clk, .rst_n, .mem_fwd, .mem_ret, .rxd, .txd, .irq_rx_valid
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Checks and test bookkeeping
    // ------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Error: %s, %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);      // Timeouts and lost handshakes
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("Test %s ok", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s had %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    // ------------------------------------------------------------
    // Bus driver, called and returning on a falling edge
    // ------------------------------------------------------------
    task automatic bus_access(input logic [3:0] offset, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata);
        int waited;
        waited        = 0;
        rdata         = '0;
        mem_fwd.valid = 1'b1;
        mem_fwd.addr  = {BASE, 20'd0, offset};
        mem_fwd.wdata = wdata;
        mem_fwd.wstrb = wstrb;                  // Zero means read
        do begin
            @(negedge clk);
            waited++;
        end while (!mem_ret.ready && waited < BUS_TIMEOUT);
        if (mem_ret.ready) rdata = mem_ret.rdata;
        else report_failure($sformatf("bus access to offset %h never got ready", offset));
        mem_fwd.valid = 1'b0;
    endtask

    task automatic bus_write(input logic [3:0] offset, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
        logic [31:0] unused_rd;
        bus_access(offset, wdata, wstrb, unused_rd);
    endtask

    task automatic bus_read(input logic [3:0] offset, output logic [31:0] rdata);
        bus_access(offset, 32'd0, 4'b0000, rdata);
    endtask

    // ------------------------------------------------------------
    // Serial line models
    // ------------------------------------------------------------
    // Finds a start bit, then samples each bit at its middle
    task automatic receive_txd(output logic [7:0] data);
        int waited;
        waited = 0;
        data   = '0;
        while (txd !== 1'b0 && waited < LINE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (txd !== 1'b0) begin
            report_failure("no start bit appeared on txd");
        end else begin
            repeat (bit_cycles / 2) @(negedge clk);
            check_value("start bit", 32'd0, 32'(txd));
            for (int i = 0; i < 8; i++) begin
                repeat (bit_cycles) @(negedge clk);
                data[i] = txd;                  // LSB first
            end
            repeat (bit_cycles) @(negedge clk);
            check_value("stop bit", 32'd1, 32'(txd));
        end
    endtask

    // One 8N1 frame on rxd, stop bit chosen by the caller
    task automatic send_rxd(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (bit_cycles) @(negedge clk);
        end
        rxd = 1'b1;
        repeat (bit_cycles * 2) @(negedge clk); // Idle gap
    endtask

    task automatic wait_irq();
        int waited;
        waited = 0;
        while (irq_rx_valid !== 1'b1 && waited < 500) begin
            @(negedge clk);
            waited++;
        end
        if (irq_rx_valid !== 1'b1) report_failure("irq_rx_valid never rose");
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_reset_state();
        logic [31:0] rd;
        start_test("reset_state");
        bus_read(uart_pkg::REG_STATUS, rd);
        check_value("status", 32'd0, rd);
        bus_read(uart_pkg::REG_BAUD, rd);
        check_value("baud", {16'd0, uart_pkg::PRESCALE_RESET}, rd);
        check_value("txd", 32'd1, 32'(txd));
        check_value("irq_rx_valid", 32'd0, 32'(irq_rx_valid));
        end_test();
    endtask

    task automatic test_baud_strobes();
        logic [31:0] rnd;
        logic [31:0] rd;
        logic [15:0] exp_ps;
        start_test("baud_strobes");
        rnd    = $urandom;
        exp_ps = {uart_pkg::PRESCALE_RESET[15:8], rnd[7:0]};   // Low byte only
        bus_write(uart_pkg::REG_BAUD, rnd, 4'b0001);
        bus_read(uart_pkg::REG_BAUD, rd);
        check_value("baud low byte", {16'd0, exp_ps}, rd);
        rnd = $urandom;
        bus_write(uart_pkg::REG_BAUD, rnd, 4'b0011);
        bus_read(uart_pkg::REG_BAUD, rd);
        check_value("baud both bytes", {16'd0, rnd[15:0]}, rd);
        bus_write(uart_pkg::REG_BAUD, 32'd8, 4'b0011);
        bus_read(uart_pkg::REG_BAUD, rd);
        check_value("baud 8", 32'd8, rd);
        bit_cycles = 16'd8;
        end_test();
    endtask

    task automatic test_tx_frame();
        logic [7:0] sent;
        logic [7:0] seen;
        start_test("tx_frame");
        sent = 8'($urandom);
        fork
            bus_write(uart_pkg::REG_TX_DATA, {24'd0, sent}, 4'b1111);
            receive_txd(seen);
        join
        check_value("txd byte", 32'(sent), 32'(seen));
        end_test();
    endtask

    task automatic test_credit_burst();
        logic [7:0]  sent [6];
        logic [7:0]  seen [6];
        logic [7:0]  got;
        logic [31:0] rd;
        logic        saw_full;
        start_test("credit_burst");
        saw_full = 1'b0;
        for (int i = 0; i < 6; i++) sent[i] = 8'($urandom);
        fork
            for (int i = 0; i < 6; i++) begin
                bus_write(uart_pkg::REG_TX_DATA, {24'd0, sent[i]}, 4'b1111);
                bus_read(uart_pkg::REG_STATUS, rd);
                if (rd[1]) saw_full = 1'b1;     // tx_full
            end
            for (int j = 0; j < 6; j++) begin
                receive_txd(got);
                seen[j] = got;
            end
        join
        check_value("tx_full seen", 32'd1, 32'(saw_full));
        for (int i = 0; i < 6; i++) check_value($sformatf("byte %0d", i), 32'(sent[i]),
                                                32'(seen[i]));
        end_test();
    endtask

    task automatic test_rx_irq();
        logic [7:0]  sent;
        logic [31:0] rd;
        start_test("rx_irq");
        sent = 8'($urandom);
        send_rxd(sent, 1'b1);
        wait_irq();
        bus_read(uart_pkg::REG_STATUS, rd);
        check_value("status rx_valid", 32'd1, 32'(rd[2]));
        bus_read(uart_pkg::REG_RX_DATA, rd);
        check_value("rx data", {24'd0, sent}, rd);
        bus_read(uart_pkg::REG_RX_DATA, rd);
        check_value("empty read", uart_pkg::RX_EMPTY_WORD, rd);
        check_value("irq_rx_valid", 32'd0, 32'(irq_rx_valid));
        end_test();
    endtask

    task automatic test_overrun_framing();
        logic [7:0]  sent [5];
        logic [31:0] rd;
        start_test("overrun_framing");
        for (int i = 0; i < 5; i++) begin
            sent[i] = 8'($urandom);
            send_rxd(sent[i], 1'b1);            // Fifth one finds the FIFO full
        end
        bus_read(uart_pkg::REG_STATUS, rd);
        check_value("rx_overrun set", 32'd1, 32'(rd[3]));
        bus_read(uart_pkg::REG_STATUS, rd);
        check_value("rx_overrun cleared", 32'd0, 32'(rd[3]));
        for (int i = 0; i < 4; i++) begin
            bus_read(uart_pkg::REG_RX_DATA, rd);
            check_value($sformatf("rx byte %0d", i), {24'd0, sent[i]}, rd);
        end
        bus_read(uart_pkg::REG_RX_DATA, rd);
        check_value("read after drain", uart_pkg::RX_EMPTY_WORD, rd);
        send_rxd(8'($urandom), 1'b0);           // Bad stop bit
        check_value("irq after bad frame", 32'd0, 32'(irq_rx_valid));
        bus_read(uart_pkg::REG_RX_DATA, rd);
        check_value("read after bad frame", uart_pkg::RX_EMPTY_WORD, rd);
        end_test();
    endtask

    // ------------------------------------------------------------
    // Run
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'hf2113527));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "reset";
        rst_n        = 1'b0;
        rxd          = 1'b1;                    // Idle line
        mem_fwd      = '0;
        bit_cycles   = uart_pkg::PRESCALE_RESET;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset_state();
        test_baud_strobes();
        test_tx_frame();
        test_credit_burst();
        test_rx_irq();
        test_overrun_framing();

        $display("Tests run %0d, tests failing %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* flist.f */
hw/mem_bus_pkg.sv
hw/uart_pkg.sv
hw/uart_regs.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_periph.sv
dv/uart_periph_props.sv
dv/uart_periph_tb.sv

/* hw/mem_bus_pkg.sv */
package mem_bus_pkg;

    // ------------------------------------------------------------
    // Packed memory bus, CPU side to peripheral
    // ------------------------------------------------------------
    typedef struct packed {
        logic        valid;     // Held until ready is seen
        logic [31:0] addr;      // Byte address, top byte selects device
        logic [31:0] wdata;
        logic [3:0]  wstrb;     // All zero means a read
    } mem_fwd_t;

    // ------------------------------------------------------------
    // Packed memory bus, peripheral back to CPU
    // ------------------------------------------------------------
    typedef struct packed {
        logic        ready;     // Single-cycle pulse per access
        logic [31:0] rdata;     // Valid with ready
    } mem_ret_t;

endpackage

/* hw/uart_fifo.sv */
`timescale 1ns/100ps

module uart_fifo #(
    parameter int depth = 4     // Power of two
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] head,    // Show-ahead, valid while not empty
    output logic       empty,
    output logic       full
);

    localparam int aw = $clog2(depth);

    logic [7:0]  mem [depth];
    logic [aw:0] wr_ptr;        // Extra bit tells full from empty
    logic [aw:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
    assign do_push = push && !full;     // Push into full is lost
    assign do_pop  = pop && !empty;     // Pop of empty does nothing
    assign head    = mem[rd_ptr[aw-1:0]];

    // ------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[aw-1:0]] <= push_data;
        end
    end

endmodule

/* hw/uart_periph.sv */
`timescale 1ns/100ps

module uart_periph #(
    parameter logic [7:0] base_addr = 8'h00
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_bus_pkg::mem_fwd_t mem_fwd,
    output mem_bus_pkg::mem_ret_t mem_ret,
    input  logic                  rxd,
    output logic                  txd,
    output logic                  irq_rx_valid
);

    logic        tx_push;
    logic [7:0]  tx_push_byte;
    logic [7:0]  tx_head;
    logic        tx_empty;
    logic        tx_pop;        // Pop strobe, returned as a credit
    logic        tx_busy;
    logic        rx_push;
    logic [7:0]  rx_push_data;
    logic        rx_drop;
    logic [7:0]  rx_head;
    logic        rx_empty;
    logic        rx_full;
    logic        rx_pop;
    logic [15:0] prescale;

    assign irq_rx_valid = !rx_empty;    // Level, while data waits

    // ------------------------------------------------------------
    // Register block
    // ------------------------------------------------------------
    uart_regs #(.base_addr(base_addr)) i_uart_regs (
        .clk, .rst_n, .mem_fwd, .mem_ret,
        .tx_credit(tx_pop), .tx_push, .tx_push_byte,
        .rx_head, .rx_empty, .rx_pop, .rx_drop,
        .tx_busy, .prescale
    );

    // ------------------------------------------------------------
    // Transmit path, credits keep the FIFO from filling past depth
    // ------------------------------------------------------------
    uart_fifo #(.depth(uart_pkg::TX_FIFO_DEPTH)) tx_fifo (
        .clk, .rst_n, .push(tx_push), .push_data(tx_push_byte),
        .pop(tx_pop), .head(tx_head), .empty(tx_empty), .full()
    );

    uart_tx i_uart_tx (
        .clk, .rst_n, .prescale, .fifo_head(tx_head), .fifo_empty(tx_empty),
        .fifo_pop(tx_pop), .busy(tx_busy), .txd
    );

    // Receive path, no back-pressure
    uart_rx i_uart_rx (
        .clk, .rst_n, .prescale, .rxd, .fifo_full(rx_full),
        .push(rx_push), .push_data(rx_push_data), .drop(rx_drop)
    );

    uart_fifo #(.depth(uart_pkg::RX_FIFO_DEPTH)) rx_fifo (
        .clk, .rst_n, .push(rx_push), .push_data(rx_push_data),
        .pop(rx_pop), .head(rx_head), .empty(rx_empty), .full(rx_full)
    );

endmodule

/* hw/uart_pkg.sv */
package uart_pkg;

    // ------------------------------------------------------------
    // Register map, offsets within the device window
    // ------------------------------------------------------------
    localparam logic [3:0] REG_TX_DATA = 4'h0;   // Write a byte to send
    localparam logic [3:0] REG_STATUS  = 4'h4;   // Read flags
    localparam logic [3:0] REG_RX_DATA = 4'h8;   // Read a received byte
    localparam logic [3:0] REG_BAUD    = 4'hC;   // Clock cycles per bit

    // Frame and buffer sizing
    localparam int DATA_BITS     = 8;
    localparam int TX_FIFO_DEPTH = 4;
    localparam int RX_FIFO_DEPTH = 4;
    localparam int CREDIT_W      = 3;            // Holds 0..TX_FIFO_DEPTH

    localparam logic [15:0] PRESCALE_RESET = 16'd16;
    localparam logic [31:0] RX_EMPTY_WORD  = 32'hFFFF_FF00;  // Read of empty RX FIFO

    // Status word, bit 0 is tx_busy, zero-extended on the bus
    typedef struct packed {
        logic rx_overrun;   // Sticky, cleared by a status read
        logic rx_valid;     // RX FIFO not empty
        logic tx_full;      // No transmit credit left
        logic tx_busy;      // Frame on the line or bytes queued
    } uart_status_t;

    // ------------------------------------------------------------
    // Bus write word, meaning depends on the register addressed
    // ------------------------------------------------------------
    typedef struct packed {
        logic [23:0] rsvd;
        logic [7:0]  tx_byte;   // Byte to transmit
    } uart_tx_view_t;

    typedef struct packed {
        logic [15:0] rsvd;
        logic [15:0] prescale;  // Cycles per bit
    } uart_baud_view_t;

    typedef union packed {
        uart_tx_view_t   tx_view;
        uart_baud_view_t baud_view;
    } uart_wdata_u;

endpackage

/* hw/uart_regs.sv */
`timescale 1ns/100ps

module uart_regs #(
    parameter logic [7:0] base_addr = 8'h00    // Device window, addr[31:24]
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_bus_pkg::mem_fwd_t mem_fwd,
    output mem_bus_pkg::mem_ret_t mem_ret,
    input  logic                  tx_credit,     // Serializer took a byte
    output logic                  tx_push,
    output logic [7:0]            tx_push_byte,
    input  logic [7:0]            rx_head,
    input  logic                  rx_empty,
    output logic                  rx_pop,
    input  logic                  rx_drop,       // Byte lost, RX FIFO full
    input  logic                  tx_busy,       // Frame on the line
    output logic [15:0]           prescale
);

    logic                            ready_q;
    logic [31:0]                     rdata_q;
    logic [uart_pkg::CREDIT_W-1:0]   credit;
    logic                            overrun;
    uart_pkg::uart_status_t          status;
    uart_pkg::uart_wdata_u           wdata_u;
    logic                            serve;
    logic                            is_write;
    logic [3:0]                      offset;
    logic                            tx_wr;
    logic                            stat_rd;
    logic                            rx_rd;
    logic                            baud_wr;
    logic                            baud_rd;

    // ------------------------------------------------------------
    // Access decode
    // ------------------------------------------------------------
    // Held request is blocked while its ready is out
    assign serve    = mem_fwd.valid && !ready_q && (mem_fwd.addr[31:24] == base_addr);
    assign is_write = |mem_fwd.wstrb;
    assign offset   = mem_fwd.addr[3:0];
    assign wdata_u  = mem_fwd.wdata;

    assign tx_wr   = serve && is_write && (offset == uart_pkg::REG_TX_DATA);
    assign stat_rd = serve && !is_write && (offset == uart_pkg::REG_STATUS);
    assign rx_rd   = serve && !is_write && (offset == uart_pkg::REG_RX_DATA);
    assign baud_wr = serve && is_write && (offset == uart_pkg::REG_BAUD);
    assign baud_rd = serve && !is_write && (offset == uart_pkg::REG_BAUD);

    // Transmit push only with a credit in hand, otherwise the write stalls
    assign tx_push      = tx_wr && (credit != '0);
    assign tx_push_byte = wdata_u.tx_view.tx_byte;
    assign rx_pop       = rx_rd && !rx_empty;   // Empty read pops nothing

    // Status word
    assign status.tx_busy    = tx_busy || (credit != uart_pkg::CREDIT_W'(uart_pkg::TX_FIFO_DEPTH));
    assign status.tx_full    = (credit == '0);
    assign status.rx_valid   = !rx_empty;
    assign status.rx_overrun = overrun;

    // ------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q  <= 1'b0;
            credit   <= uart_pkg::CREDIT_W'(uart_pkg::TX_FIFO_DEPTH);
            prescale <= uart_pkg::PRESCALE_RESET;
            overrun  <= 1'b0;
        end else begin
            // Every served access completes, except a write with no credit
            ready_q <= serve && !(tx_wr && !tx_push);

            // Push and return may land on the same cycle
            case ({tx_push, tx_credit})
                2'b10:   credit <= credit - 1'b1;
                2'b01:   credit <= credit + 1'b1;
                default: credit <= credit;
            endcase

            if (baud_wr && mem_fwd.wstrb[0]) prescale[7:0]  <= wdata_u.baud_view.prescale[7:0];
            if (baud_wr && mem_fwd.wstrb[1]) prescale[15:8] <= wdata_u.baud_view.prescale[15:8];

            // A drop on the read cycle stays visible
            overrun <= rx_drop || (overrun && !stat_rd);
        end
    end

    // Read data, meaningful only with ready
    always_ff @(posedge clk) begin
        rdata_q <= '0;
        if (stat_rd) begin
            rdata_q <= {28'd0, status};
        end else if (rx_rd) begin
            rdata_q <= rx_empty ? uart_pkg::RX_EMPTY_WORD : {24'd0, rx_head};
        end else if (baud_rd) begin
            rdata_q <= {16'd0, prescale};
        end
    end

    assign mem_ret.ready = ready_q;
    assign mem_ret.rdata = rdata_q;

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] prescale,
    input  logic        rxd,
    input  logic        fifo_full,
    output logic        push,
    output logic [7:0]  push_data,
    output logic        drop        // Good frame lost to a full FIFO
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t                              state;
    logic                                   rxd_m;    // Synchronizer stage 1
    logic                                   rxd_s;    // Synchronizer stage 2
    logic                                   rxd_d;    // For edge detect
    logic [15:0]                            period;
    logic [15:0]                            cnt;
    logic [uart_pkg::DATA_BITS-1:0]         shreg;
    logic [$clog2(uart_pkg::DATA_BITS)-1:0] bit_idx;
    logic                                   stop_ok;

    // Mid-stop sample with a good stop bit ends the frame
    assign stop_ok   = (state == STOP) && (cnt == '0) && rxd_s;
    assign push      = stop_ok && !fifo_full;
    assign drop      = stop_ok && fifo_full;
    assign push_data = shreg;

    // ------------------------------------------------------------
    // Synchronizer
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_m <= 1'b1;
            rxd_s <= 1'b1;
            rxd_d <= 1'b1;
        end else begin
            rxd_m <= rxd;
            rxd_s <= rxd_m;
            rxd_d <= rxd_s;
        end
    end

    // ------------------------------------------------------------
    // Frame FSM, samples at mid-bit
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            period  <= uart_pkg::PRESCALE_RESET;
            cnt     <= '0;
            shreg   <= '0;
            bit_idx <= '0;
        end else if (state == IDLE) begin
            if (rxd_d && !rxd_s) begin                  // Falling start edge
                state  <= START;
                period <= prescale;
                cnt    <= {1'b0, prescale[15:1]} - 1'b1; // Half a bit
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            cnt <= period - 1'b1;
            case (state)
                START: begin
                    bit_idx <= '0;
                    state   <= rxd_s ? IDLE : DATA;     // High again means glitch
                end
                DATA: begin
                    shreg <= {rxd_s, shreg[uart_pkg::DATA_BITS-1:1]};
                    if (bit_idx == ($bits(bit_idx))'(uart_pkg::DATA_BITS - 1)) begin
                        state <= STOP;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: state <= IDLE;     // Stop of 0 is a framing error, dropped silently
            endcase
        end
    end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] prescale,
    input  logic [7:0]  fifo_head,
    input  logic        fifo_empty,
    output logic        fifo_pop,   // Doubles as the credit return
    output logic        busy,
    output logic        txd
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_t;

    tx_state_t                              state;
    logic [15:0]                            period;   // Latched per frame
    logic [15:0]                            cnt;      // Cycles left in the bit
    logic [uart_pkg::DATA_BITS-1:0]         shreg;
    logic [$clog2(uart_pkg::DATA_BITS)-1:0] bit_idx;

    assign fifo_pop = (state == IDLE) && !fifo_empty;
    assign busy     = (state != IDLE);

    // ------------------------------------------------------------
    // Frame FSM, LSB first
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            txd     <= 1'b1;    // Line idles high
            period  <= uart_pkg::PRESCALE_RESET;
            cnt     <= '0;
            shreg   <= '0;
            bit_idx <= '0;
        end else if (state == IDLE) begin
            if (fifo_pop) begin
                state  <= START;
                txd    <= 1'b0;                 // Start bit
                period <= prescale;             // New prescale applies here
                cnt    <= prescale - 1'b1;
                shreg  <= fifo_head;
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            cnt <= period - 1'b1;
            case (state)
                START: begin
                    state   <= DATA;
                    txd     <= shreg[0];
                    shreg   <= shreg >> 1;
                    bit_idx <= '0;
                end
                DATA: begin
                    if (bit_idx == ($bits(bit_idx))'(uart_pkg::DATA_BITS - 1)) begin
                        state <= STOP;
                        txd   <= 1'b1;          // Stop bit
                    end else begin
                        txd     <= shreg[0];
                        shreg   <= shreg >> 1;
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: state <= IDLE;         // End of stop, pop next cycle
            endcase
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UART peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module uart_periph_tb -f flist.f \
    -o sim_uart > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_uart > sim.log 2>&1
run_status=$?
cat sim.log

# A nonzero exit or the fail message in the log means failure
[ "$run_status" -eq 0 ] && ! grep -q "Verification failed" sim.log \
    && { echo "Simulation ok"; exit 0; } \
    || { echo "Simulation reported failure"; exit 1; }
